// File: hw/gem_format_pkg.sv
`default_nettype none

package gem_format_pkg;

  // ------------------------------
  // Cluster format
  // ------------------------------
  localparam int num_clusters = 4;                          // Clusters per packed word
  localparam int cluster_bits = 14;                         // Count plus pad address
  localparam int adr_bits     = 11;                         // Pad address field
  localparam int cnt_bits     = 3;                          // Cluster size count
  localparam int half_bits    = 7;                          // Raw store parity granule
  localparam int rx_bits      = num_clusters * cluster_bits; // Packed trigger word, 56 bits

  // ------------------------------
  // Memory sizes
  // ------------------------------
  localparam int raw_depth    = 2048;                       // Raw hits depth in bx
  localparam int raw_adr_bits = $clog2(raw_depth);          // 11
  localparam int cap_depth    = 1024;                       // Debug snapshot depth
  localparam int cap_adr_bits = $clog2(cap_depth);          // 10

  // ------------------------------
  // Types
  // ------------------------------
  // One cluster as it sits in the word
  typedef struct packed {
    logic [cnt_bits-1:0] cnt;                               // Bits 13:11
    logic [adr_bits-1:0] adr;                               // Bits 10:0
  } cluster_t;

  typedef logic [$clog2(num_clusters)-1:0] cluster_sel_t;   // Cluster index 0..3
  typedef logic [raw_adr_bits-1:0]         raw_adr_t;       // Raw store address
  typedef logic [cap_adr_bits-1:0]         cap_adr_t;       // Snapshot address
  typedef logic [num_clusters-1:0]         vpf_t;           // One flag per cluster

endpackage

`default_nettype wire

// File: hw/gem_regs_pkg.sv
`default_nettype none

package gem_regs_pkg;

  // ------------------------------
  // APB address map
  // ------------------------------
  localparam int paddr_bits = 15;                           // Byte address width

  localparam logic [paddr_bits-1:0] status_addr  = 15'h0000; // Capture state in bits 1:0
  localparam logic [paddr_bits-1:0] control_addr = 15'h0004; // Bit 0 rearms the capture

  // Set for snapshot reads, index in 13:4 and cluster in 3:2
  localparam int data_region_bit = 14;

  // ------------------------------
  // Capture state and access decode
  // ------------------------------
  typedef enum logic [1:0] {
    cap_ready   = 2'd0,                                     // Armed, waiting for a valid cluster
    cap_writing = 2'd1,                                     // Filling the snapshot
    cap_readout = 2'd2                                      // Full and frozen
  } capture_state_t;

  typedef enum logic [2:0] {
    op_none          = 3'd0,                                // No slave selected
    op_status_read   = 3'd1,
    op_control_write = 3'd2,
    op_data_read     = 3'd3,                                // Two access cycles
    op_error         = 3'd4                                 // Answered with pslverr
  } apb_op_t;

endpackage

`default_nettype wire

// File: hw/gem_cluster_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gem_cluster_decode (
  input  wire                                clock,          // System clock
  input  wire                                reset,          // Synchronous active-high reset
  input  wire [gem_format_pkg::rx_bits-1:0]  rx_data,        // Packed trigger word
  output gem_format_pkg::cluster_t           cluster [gem_format_pkg::num_clusters],
  output gem_format_pkg::vpf_t               vpf,            // Valid pattern flags
  output logic                               word_has_data,  // At least one valid cluster
  output logic                               rx_nonzero      // Some bit of the word set
);

  import gem_format_pkg::*;

  // ------------------------------
  // Field split
  // ------------------------------
  cluster_t field [num_clusters];                            // Clusters before the register
  vpf_t     vpf_next;                                        // Flags before the register

  always_comb begin
    for (int i = 0; i < num_clusters; i++) begin
      field[i]    = rx_data[i*cluster_bits +: cluster_bits]; // Field 0 in the low bits
      vpf_next[i] = ~&field[i].adr[adr_bits-1 -: 2];         // Address 11xx.. marks an empty slot
    end
  end

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge clock) begin
    for (int i = 0; i < num_clusters; i++) begin
      cluster[i] <= field[i];                                // Same cycle as the flags
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      vpf           <= '0;
      word_has_data <= 1'b0;
      rx_nonzero    <= 1'b0;
    end else begin
      vpf           <= vpf_next;
      word_has_data <= |vpf_next;                            // Capture trigger
      rx_nonzero    <= |rx_data;                             // Link activity
    end
  end

endmodule

`default_nettype wire

// File: hw/gem_raw_hits_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gem_raw_hits_ram (
  input  wire                                clock,       // System clock
  input  wire gem_format_pkg::cluster_t      cluster [gem_format_pkg::num_clusters],
  input  wire                                fifo_wen,    // Host write strobe
  input  wire gem_format_pkg::raw_adr_t      fifo_wadr,   // Write bx address
  input  wire gem_format_pkg::raw_adr_t      fifo_radr,   // Read bx address
  input  wire gem_format_pkg::cluster_sel_t  fifo_sel,    // Cluster to return
  output gem_format_pkg::cluster_t           fifo_rdata,  // Selected cluster
  output gem_format_pkg::vpf_t               parity_err   // Per-cluster read check
);

  import gem_format_pkg::*;

  typedef logic [half_bits:0] half_t;                     // Parity bit above 7 data bits

  half_t        rd_lo [num_clusters];                     // Lower halves read back
  half_t        rd_hi [num_clusters];                     // Upper halves read back
  cluster_sel_t sel_q;                                    // Select aligned with read data
  cluster_t     rd_cluster [num_clusters];                // Halves joined again

  // ------------------------------
  // Stores, two halves per cluster
  // ------------------------------
  for (genvar c = 0; c < num_clusters; c++) begin : g_store
    half_t                mem_lo [raw_depth];             // Bits 6:0 with parity
    half_t                mem_hi [raw_depth];             // Bits 13:7 with parity
    logic [half_bits-1:0] wr_lo;
    logic [half_bits-1:0] wr_hi;

    assign wr_lo = cluster[c][half_bits-1:0];
    assign wr_hi = cluster[c][cluster_bits-1:half_bits];

    always_ff @(posedge clock) begin
      if (fifo_wen) begin
        mem_lo[fifo_wadr] <= {~^wr_lo, wr_lo};            // Odd parity per half
        mem_hi[fifo_wadr] <= {~^wr_hi, wr_hi};
      end
      rd_lo[c] <= mem_lo[fifo_radr];                      // Old data on a same-address write
      rd_hi[c] <= mem_hi[fifo_radr];
    end
  end

  always_ff @(posedge clock) begin
    sel_q <= fifo_sel;
  end

  // ------------------------------
  // Parity check and output select
  // ------------------------------
  always_comb begin
    for (int c = 0; c < num_clusters; c++) begin
      rd_cluster[c] = {rd_hi[c][half_bits-1:0], rd_lo[c][half_bits-1:0]};
      // Stored bit against parity rebuilt from the data
      parity_err[c] = (rd_lo[c][half_bits] != ~^rd_lo[c][half_bits-1:0])
                    | (rd_hi[c][half_bits] != ~^rd_hi[c][half_bits-1:0]);
    end
  end

  assign fifo_rdata = rd_cluster[sel_q];                  // One cycle after radr and sel

  // ------------------------------
  // Checks
  // ------------------------------
  // The host must present a defined location with every write
  a_wr_known : assert property (@(posedge clock)
    fifo_wen |-> !$isunknown({fifo_wadr, fifo_sel}))
    else $error("raw hits write with unknown address or select");

endmodule

`default_nettype wire

// File: hw/gem_capture_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gem_capture_ram (
  input  wire                                clock,      // System clock
  input  wire gem_format_pkg::cluster_t      cluster [gem_format_pkg::num_clusters],
  input  wire                                cap_wen,    // High through the whole burst
  input  wire gem_format_pkg::cap_adr_t      cap_wadr,   // Burst word index
  input  wire gem_format_pkg::cap_adr_t      cap_radr,   // Readout word index
  input  wire gem_format_pkg::cluster_sel_t  cap_rsel,   // Readout cluster
  output gem_format_pkg::cluster_t           cap_rdata,  // Selected cluster
  output logic                               cap_perr    // Parity mismatch on that cluster
);

  import gem_format_pkg::*;

  typedef logic [cluster_bits:0] entry_t;                 // Parity bit above the cluster

  cluster_t     wr_q [num_clusters];                      // Decoded word one cycle back
  entry_t       rd_q [num_clusters];                      // All four at cap_radr
  entry_t       rd_sel;                                   // Chosen entry
  cluster_sel_t sel_q;                                    // Select aligned with read data

  // The FSM enters writing one cycle after the trigger word,
  // so the write data is taken from this delay stage
  always_ff @(posedge clock) begin
    for (int c = 0; c < num_clusters; c++) begin
      wr_q[c] <= cluster[c];
    end
    sel_q <= cap_rsel;
  end

  // ------------------------------
  // Snapshot stores
  // ------------------------------
  for (genvar c = 0; c < num_clusters; c++) begin : g_store
    entry_t mem [cap_depth];                              // 1024 x 15

    always_ff @(posedge clock) begin
      if (cap_wen) begin
        mem[cap_wadr] <= {~^wr_q[c], wr_q[c]};            // Odd parity over 14 bits
      end
      rd_q[c] <= mem[cap_radr];
    end
  end

  // ------------------------------
  // Readout
  // ------------------------------
  assign rd_sel    = rd_q[sel_q];
  assign cap_rdata = rd_sel[cluster_bits-1:0];
  assign cap_perr  = rd_sel[cluster_bits] != ~^rd_sel[cluster_bits-1:0];

endmodule

`default_nettype wire

// File: hw/gem_capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gem_capture_ctrl (
  input  wire                                clock,          // System clock
  input  wire                                reset,          // Synchronous active-high reset
  input  wire                                word_has_data,  // Trigger from the decoder
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire [gem_regs_pkg::paddr_bits-1:0] paddr,
  input  wire [31:0]                         pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               cap_wen,        // Snapshot write strobe
  output gem_format_pkg::cap_adr_t           cap_wadr,       // Burst counter
  output gem_format_pkg::cap_adr_t           cap_radr,       // From paddr 13:4
  output gem_format_pkg::cluster_sel_t       cap_rsel,       // From paddr 3:2
  input  wire gem_format_pkg::cluster_t      cap_rdata,
  input  wire                                cap_perr
);

  import gem_format_pkg::*;
  import gem_regs_pkg::*;

  capture_state_t state;                                     // Capture FSM
  apb_op_t        op;                                        // Current access kind
  logic           access;                                    // APB access phase
  logic           data_wait;                                 // Snapshot read in its second cycle
  logic           rearm;                                     // Control write with bit 0 set

  // ------------------------------
  // APB decode
  // ------------------------------
  always_comb begin
    if (!psel) begin
      op = op_none;
    end else if (paddr[data_region_bit]) begin
      op = pwrite ? op_error : op_data_read;                 // Snapshot is read only
    end else if (paddr == status_addr) begin
      op = pwrite ? op_error : op_status_read;
    end else if (paddr == control_addr && pwrite) begin
      op = op_control_write;
    end else begin
      op = op_error;                                         // Unmapped or control read
    end
  end

  assign access  = psel && penable;
  assign pready  = access && (op != op_data_read || data_wait); // Store read costs one wait
  assign pslverr = pready && (op == op_error);
  assign rearm   = pready && (op == op_control_write) && pwdata[0];

  always_ff @(posedge clock) begin
    if (reset) begin
      data_wait <= 1'b0;
    end else begin
      data_wait <= access && (op == op_data_read) && !data_wait;
    end
  end

  assign cap_radr = paddr[data_region_bit-1 -: cap_adr_bits];
  assign cap_rsel = paddr[data_region_bit-cap_adr_bits-1 -: 2];

  always_comb begin
    prdata = '0;
    if (pready) begin
      case (op)
        op_status_read: prdata[1:0] = state;
        op_data_read: begin
          prdata[cluster_bits-1:0] = cap_rdata;
          prdata[31]               = cap_perr;
        end
        default: prdata = '0;
      endcase
    end
  end

  // ------------------------------
  // Capture FSM and write counter
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset || rearm) begin
      state <= cap_ready;                                    // Rearm wins in every state
    end else begin
      case (state)
        cap_ready:   if (word_has_data) state <= cap_writing;
        cap_writing: if (cap_wadr == cap_adr_t'(cap_depth - 1)) state <= cap_readout;
        cap_readout: state <= cap_readout;                   // Held until rearm
        default:     state <= cap_ready;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset || state == cap_ready) begin
      cap_wadr <= '0;
    end else if (state == cap_writing) begin
      cap_wadr <= cap_wadr + 1'b1;
    end
  end

  assign cap_wen = (state == cap_writing);

  // ------------------------------
  // Checks
  // ------------------------------
  // A burst opens at word 0 after a trigger and then fills consecutive words
  a_wen_burst : assert property (@(posedge clock) disable iff (reset)
    cap_wen |-> ($past(cap_wen) ? cap_wadr == cap_adr_t'($past(cap_wadr) + 1'b1)
                                : cap_wadr == '0 && $past(word_has_data)))
    else $error("snapshot write outside a triggered consecutive burst");

  // The master must leave the access phase after each completion
  a_pready_pulse : assert property (@(posedge clock) disable iff (reset)
    pready |=> !pready)
    else $error("pready high on two cycles in a row");

endmodule

`default_nettype wire

// File: hw/gem_top.sv
`timescale 1ns/1ps
`default_nettype none

module gem_top (
  input  wire                                clock,        // System clock
  input  wire                                reset,        // Synchronous active-high reset
  input  wire [gem_format_pkg::rx_bits-1:0]  rx_data,      // Packed word every cycle
  // Raw hits store
  input  wire                                fifo_wen,
  input  wire gem_format_pkg::raw_adr_t      fifo_wadr,
  input  wire gem_format_pkg::raw_adr_t      fifo_radr,
  input  wire gem_format_pkg::cluster_sel_t  fifo_sel,
  // APB slave for snapshot status and readout
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire [gem_regs_pkg::paddr_bits-1:0] paddr,
  input  wire [31:0]                         pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  // Decoded trigger data
  output gem_format_pkg::cluster_t           gem_cluster [gem_format_pkg::num_clusters],
  output gem_format_pkg::vpf_t               gem_vpf,
  output logic                               rx_nonzero,
  output gem_format_pkg::cluster_t           fifo_rdata,
  output gem_format_pkg::vpf_t               parity_err
);

  import gem_format_pkg::*;

  logic         word_has_data;                              // Decoder to capture FSM
  logic         cap_wen;
  cap_adr_t     cap_wadr;
  cap_adr_t     cap_radr;
  cluster_sel_t cap_rsel;
  cluster_t     cap_rdata;
  logic         cap_perr;

  gem_cluster_decode gem_cluster_decode_inst (
    .clock         (clock),
    .reset         (reset),
    .rx_data       (rx_data),
    .cluster       (gem_cluster),                           // Also feeds both stores
    .vpf           (gem_vpf),
    .word_has_data (word_has_data),
    .rx_nonzero    (rx_nonzero)
  );

  gem_raw_hits_ram gem_raw_hits_ram_inst (
    .clock      (clock),
    .cluster    (gem_cluster),
    .fifo_wen   (fifo_wen),
    .fifo_wadr  (fifo_wadr),
    .fifo_radr  (fifo_radr),
    .fifo_sel   (fifo_sel),
    .fifo_rdata (fifo_rdata),
    .parity_err (parity_err)
  );

  gem_capture_ram gem_capture_ram_inst (
    .clock     (clock),
    .cluster   (gem_cluster),
    .cap_wen   (cap_wen),
    .cap_wadr  (cap_wadr),
    .cap_radr  (cap_radr),
    .cap_rsel  (cap_rsel),
    .cap_rdata (cap_rdata),
    .cap_perr  (cap_perr)
  );

  gem_capture_ctrl gem_capture_ctrl_inst (
    .clock         (clock),
    .reset         (reset),
    .word_has_data (word_has_data),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .cap_wen       (cap_wen),
    .cap_wadr      (cap_wadr),
    .cap_radr      (cap_radr),
    .cap_rsel      (cap_rsel),
    .cap_rdata     (cap_rdata),
    .cap_perr      (cap_perr)
  );

endmodule

`default_nettype wire

// File: testbench/gem_model.svh
// ------------------------------
// Reference model state
// ------------------------------
logic [rx_bits-1:0] raw_word [raw_depth];   // Word last stored per raw address
logic [rx_bits-1:0] cap_word [cap_depth];   // Words of the current snapshot
capture_state_t     m_state = cap_ready;    // Expected capture state
int                 m_cnt   = 0;            // Snapshot words taken so far

// All four clusters with address bits 10:9 set, never valid
function automatic logic [rx_bits-1:0] idle_word();
  logic [rx_bits-1:0] w;
  w = '0;
  for (int i = 0; i < num_clusters; i++) begin
    w[i*cluster_bits + 9 +: 2] = 2'b11;
  end
  return w;
endfunction

function automatic cluster_t cluster_of(input logic [rx_bits-1:0] w, input int c);
  return cluster_t'(w[c*cluster_bits +: cluster_bits]);   // Field 0 lowest
endfunction

function automatic vpf_t vpf_of(input logic [rx_bits-1:0] w);
  vpf_t v;
  cluster_t cl;
  for (int i = 0; i < num_clusters; i++) begin
    cl   = cluster_of(w, i);
    v[i] = !(cl.adr[10] && cl.adr[9]);                     // 11 in the top bits is empty
  end
  return v;
endfunction

// One clock of rx_data seen by the capture path
function automatic void model_step(input logic [rx_bits-1:0] w);
  if (m_state == cap_ready && vpf_of(w) != '0) begin
    m_state = cap_writing;                                 // Trigger word is index 0
    m_cnt   = 0;
  end
  if (m_state == cap_writing) begin
    cap_word[m_cnt] = w;
    m_cnt++;
    if (m_cnt == cap_depth) m_state = cap_readout;         // Frozen until rearm
  end
endfunction

// File: testbench/tb_gem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gem;

  import gem_format_pkg::*;
  import gem_regs_pkg::*;

  localparam int reset_cycles = 8;
  localparam int dec_words    = 200;                       // Decode test length
  localparam int raw_writes   = 64;
  localparam int cap_samples  = 32;                        // Random snapshot indices per check
  localparam int stim_cycles  = 60 + dec_words + raw_writes * 6
                              + 2 * (cap_samples + 2) * num_clusters * 4 + 2 * cap_depth;
  localparam int wd_ns        = (reset_cycles + stim_cycles + 4 * cap_depth + 1000) * 8;

  `include "gem_model.svh"

  logic                  clock;
  logic                  reset;
  logic [rx_bits-1:0]    rx_data;
  logic                  fifo_wen;
  raw_adr_t              fifo_wadr;
  raw_adr_t              fifo_radr;
  cluster_sel_t          fifo_sel;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [paddr_bits-1:0] paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  cluster_t              gem_cluster [num_clusters];
  vpf_t                  gem_vpf;
  logic                  rx_nonzero;
  cluster_t              fifo_rdata;
  vpf_t                  parity_err;
  int                    error_count = 0;
  raw_adr_t              raw_q [$];                        // Addresses written in the raw test

  gem_top gem_top_inst (.*);

  always #4 clock = ~clock;                                // 8 ns period

  always @(posedge clock) begin
    if (!reset) model_step(rx_data);                       // Word sampled on this edge
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_cluster(input string name, input cluster_t exp, input cluster_t act);
    if (act !== exp) report_failure($sformatf("ERR %0t %s expected %h actual %h",
                                              $time, name, exp, act));
  endtask

  task automatic check_vpf(input string name, input vpf_t exp, input vpf_t act);
    if (act !== exp) report_failure($sformatf("ERR %0t %s expected %b actual %b",
                                              $time, name, exp, act));
  endtask

  task automatic check_state(input string name, input capture_state_t exp,
                             input capture_state_t act);
    if (act !== exp) report_failure($sformatf("ERR %0t %s expected %s actual %s",
                                              $time, name, exp.name(), act.name()));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) report_failure($sformatf("ERR %0t %s expected %b actual %b",
                                              $time, name, exp, act));
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic next_cycle();
    @(posedge clock);
    #1;                                                    // Drive point after the edge
  endtask

  // About a quarter of clusters made empty
  function automatic logic [rx_bits-1:0] rand_word();
    logic [rx_bits-1:0] w;
    w = rx_bits'({$urandom, $urandom});
    for (int i = 0; i < num_clusters; i++) begin
      if ($urandom % 4 == 0) w[i*cluster_bits + 9 +: 2] = 2'b11;
    end
    return w;
  endfunction

  task automatic apb_access(input logic write, input logic [paddr_bits-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
    psel    = 1'b1;                                        // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    waits   = 0;
    next_cycle();
    penable = 1'b1;
    #6;                                                    // Sample just before the edge
    while (!pready) begin
      waits++;
      if (waits > 16) report_failure("APB access never completed with pready");
      next_cycle();
      #6;
    end
    rdata = prdata;
    err   = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_status(input capture_state_t exp);
    logic [31:0] rd;
    logic        err;
    int          waits;
    apb_access(1'b0, status_addr, 32'h0, rd, err, waits);
    check_bit("pslverr", 1'b0, err);
    check_state("status", exp, capture_state_t'(rd[1:0]));
  endtask

  task automatic wait_capture_full();
    rx_data = idle_word();
    while (m_state != cap_readout) next_cycle();
    repeat (4) next_cycle();                               // FSM trails the model by two edges
  endtask

  task automatic check_capture();
    logic [31:0] rd;
    logic        err;
    int          waits;
    int          idx;
    for (int n = 0; n < cap_samples + 2; n++) begin
      idx = (n == 0) ? 0 : (n == 1) ? cap_depth - 1 : $urandom % cap_depth;
      for (int c = 0; c < num_clusters; c++) begin
        apb_access(1'b0, paddr_bits'((1 << data_region_bit) | (idx << 4) | (c << 2)),
                   32'h0, rd, err, waits);
        check_cluster("prdata", cluster_of(cap_word[idx], c), cluster_t'(rd[13:0]));
        check_bit("prdata[31]", 1'b0, rd[31]);
        check_bit("pslverr", 1'b0, err);
        if (waits != 1) report_failure("snapshot read did not take exactly one wait cycle");
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [rx_bits-1:0] w;
    logic [31:0]        rd;
    logic               err;
    int                 waits;
    raw_adr_t           a;
    clock     = 1'b0;
    reset     = 1'b1;
    rx_data   = idle_word();
    fifo_wen  = 1'b0;
    fifo_wadr = '0;
    fifo_radr = '0;
    fifo_sel  = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    void'($urandom(32'h9c34a178));
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b0;

    // No valid cluster yet, capture stays armed
    repeat (20) next_cycle();
    read_status(cap_ready);

    // Decode, first valid word also triggers the snapshot
    for (int n = 0; n < dec_words; n++) begin
      w = (n == dec_words / 2) ? '0 : rand_word();
      rx_data = w;
      next_cycle();
      for (int c = 0; c < num_clusters; c++) begin
        check_cluster($sformatf("gem_cluster[%0d]", c), cluster_of(w, c), gem_cluster[c]);
      end
      check_vpf("gem_vpf", vpf_of(w), gem_vpf);
      check_bit("rx_nonzero", |w, rx_nonzero);
    end

    // Raw hits store, write one cycle after the word
    for (int n = 0; n < raw_writes; n++) begin
      a = raw_adr_t'($urandom % raw_depth);
      w = rand_word();
      rx_data = w;
      next_cycle();
      fifo_wen  = 1'b1;
      fifo_wadr = a;
      rx_data   = idle_word();
      next_cycle();
      fifo_wen = 1'b0;
      raw_word[a] = w;
      raw_q.push_back(a);
    end
    foreach (raw_q[i]) begin
      for (int c = 0; c < num_clusters; c++) begin
        fifo_radr = raw_q[i];
        fifo_sel  = cluster_sel_t'(c);
        next_cycle();
        check_cluster("fifo_rdata", cluster_of(raw_word[raw_q[i]], c), fifo_rdata);
        check_vpf("parity_err", '0, parity_err);
      end
    end

    // First snapshot
    wait_capture_full();
    read_status(cap_readout);
    check_capture();

    // Rearm and a second snapshot
    apb_access(1'b1, control_addr, 32'h1, rd, err, waits);
    check_bit("pslverr", 1'b0, err);
    m_state = cap_ready;
    m_cnt   = 0;
    repeat (2) next_cycle();
    read_status(cap_ready);
    for (int n = 0; n < cap_depth + 8; n++) begin
      w = rand_word();
      if (n == 0) w[10] = 1'b0;                            // Cluster 0 valid, sure trigger
      rx_data = w;
      next_cycle();
    end
    wait_capture_full();
    read_status(cap_readout);
    check_capture();

    // Slave error responses
    apb_access(1'b1, paddr_bits'(1 << data_region_bit), 32'h0, rd, err, waits);
    check_bit("pslverr", 1'b1, err);
    apb_access(1'b1, status_addr, 32'h0, rd, err, waits);
    check_bit("pslverr", 1'b1, err);
    apb_access(1'b0, 15'h0008, 32'h0, rd, err, waits);
    check_bit("pslverr", 1'b1, err);

    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial begin
    #(wd_ns);
    report_failure("watchdog timeout, the simulation ran too long");
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
hw/gem_format_pkg.sv
hw/gem_regs_pkg.sv
hw/gem_cluster_decode.sv
hw/gem_raw_hits_ram.sv
hw/gem_capture_ram.sv
hw/gem_capture_ctrl.sv
hw/gem_top.sv
testbench/tb_gem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the GEM receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_gem -o tb_gem_sim

out=$(./obj_dir/tb_gem_sim || true)
echo "$out"
echo "$out" | grep -q "Done: no errors"
